// File: logic/mem_stage_pkg.sv
package mem_stage_pkg;

  localparam int RAM_ADDR_BITS = 10; // 1024 words of data RAM.

  // size field of the funct3 width code, the upper bit marks unsigned loads.
  localparam logic [1:0] SIZE_BYTE = 2'b00;
  localparam logic [1:0] SIZE_HALF = 2'b01;
  localparam logic [1:0] SIZE_WORD = 2'b10;
  localparam int UNSIGNED_BIT = 2;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [3:0] byte_sel_t;
  typedef logic [2:0] width_t;

  // one execute result as it enters the memory stage.
  typedef struct packed {
    logic valid;
    logic load;
    logic store;
    logic wren;
    reg_addr_t waddr;
    word_t address;
    word_t sdata;
    width_t width;
    word_t wdata;  // alu result, replaced by the load data.
  } calc_t;

  typedef struct packed {
    calc_t calc0;
    calc_t calc1;
  } pair_t;

  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    logic [29:0] adr;  // word address.
    byte_sel_t sel;
    word_t dat;
  } wb_req_t;

  typedef struct packed {
    logic ack;
    word_t dat;
  } wb_rsp_t;

  typedef struct packed {
    logic wren;
    reg_addr_t waddr;
    word_t wdata;
  } forward_t;

  typedef enum logic [1:0] {
    bus_idle,
    bus_wait,
    bus_done
  } bus_state_t;

endpackage

// File: logic/access_decode.sv
module access_decode (
  input mem_stage_pkg::pair_t pair,
  output logic request,
  output mem_stage_pkg::wb_req_t req
);

  mem_stage_pkg::calc_t slot;
  logic mem0;
  logic mem1;
  logic [1:0] offset;

  always_comb begin
    mem0 = pair.calc0.valid & (pair.calc0.load | pair.calc0.store);
    mem1 = pair.calc1.valid & (pair.calc1.load | pair.calc1.store);
    request = mem0 | mem1;
    slot = mem0 ? pair.calc0 : pair.calc1; // slot 0 wins when both qualify.
    offset = slot.address[1:0];

    req.cyc = request;
    req.stb = request;
    req.we = slot.store;
    req.adr = slot.address[31:2];

    if (slot.load) begin
      req.sel = 4'b1111; // loads fetch the whole word and pick lanes later.
    end else begin
      case (slot.width[1:0])
        mem_stage_pkg::SIZE_BYTE: req.sel = 4'b0001 << offset;
        mem_stage_pkg::SIZE_HALF: req.sel = 4'b0011 << {offset[1], 1'b0};
        default: req.sel = 4'b1111;
      endcase
    end

    // move the store data up to the lane it lands in.
    case (slot.width[1:0])
      mem_stage_pkg::SIZE_BYTE: begin
        req.dat = {24'b0, slot.sdata[7:0]} << {offset, 3'b000};
      end
      mem_stage_pkg::SIZE_HALF: begin
        req.dat = {16'b0, slot.sdata[15:0]} << {offset[1], 4'b0000};
      end
      default: begin
        req.dat = slot.sdata;
      end
    endcase
  end

endmodule

// File: logic/bus_cycle.sv
module bus_cycle (
  input logic clock,
  input logic reset,
  input logic request,
  input mem_stage_pkg::wb_req_t req_in,
  output mem_stage_pkg::wb_req_t wb_req,
  input mem_stage_pkg::wb_rsp_t wb_rsp,
  output logic done,
  output mem_stage_pkg::word_t rdata
);

  mem_stage_pkg::bus_state_t state;
  mem_stage_pkg::wb_req_t held; // fields frozen for the length of the cycle.

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= mem_stage_pkg::bus_idle;
    end else begin
      case (state)
        mem_stage_pkg::bus_idle: begin
          if (request) begin
            state <= mem_stage_pkg::bus_wait;
          end
        end
        mem_stage_pkg::bus_wait: begin
          if (wb_rsp.ack) begin
            state <= mem_stage_pkg::bus_done;
          end
        end
        default: begin
          state <= mem_stage_pkg::bus_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == mem_stage_pkg::bus_idle && request) begin
      held <= req_in;
    end
    if (state == mem_stage_pkg::bus_wait && wb_rsp.ack) begin
      rdata <= wb_rsp.dat;
    end
  end

  // the cycle opens straight from the decoder so the slave sees it a cycle early.
  always_comb begin
    case (state)
      mem_stage_pkg::bus_idle: begin
        wb_req = req_in;
        wb_req.cyc = request;
        wb_req.stb = request;
      end
      mem_stage_pkg::bus_wait: begin
        wb_req = held;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
      end
      default: begin
        wb_req = held;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
      end
    endcase
    done = (state == mem_stage_pkg::bus_done);
  end

endmodule

// File: logic/load_align.sv
module load_align (
  input mem_stage_pkg::word_t rdata,
  input logic [1:0] offset,
  input mem_stage_pkg::width_t width,
  output mem_stage_pkg::word_t result
);

  mem_stage_pkg::word_t shifted;
  logic sign;

  always_comb begin
    shifted = rdata >> {offset, 3'b000}; // addressed lane down to bit 0.
    sign = 1'b0;

    case (width[1:0])
      mem_stage_pkg::SIZE_BYTE: begin
        sign = shifted[7] & ~width[mem_stage_pkg::UNSIGNED_BIT];
        result = {{24{sign}}, shifted[7:0]};
      end
      mem_stage_pkg::SIZE_HALF: begin
        sign = shifted[15] & ~width[mem_stage_pkg::UNSIGNED_BIT];
        result = {{16{sign}}, shifted[15:0]};
      end
      mem_stage_pkg::SIZE_WORD: begin
        result = rdata;
      end
      default: begin
        result = rdata; // no wider loads on a 32 bit core.
      end
    endcase
  end

endmodule

// File: logic/memory_stage.sv
module memory_stage (
  input logic clock,
  input logic reset,
  input logic clear,
  input mem_stage_pkg::pair_t d,
  output logic stall,
  output mem_stage_pkg::wb_req_t wb_req,
  input mem_stage_pkg::wb_rsp_t wb_rsp,
  output mem_stage_pkg::forward_t forward0,
  output mem_stage_pkg::forward_t forward1,
  output mem_stage_pkg::pair_t q
);

  mem_stage_pkg::pair_t r;
  mem_stage_pkg::pair_t w;
  mem_stage_pkg::wb_req_t dec_req;
  mem_stage_pkg::word_t rdata;
  mem_stage_pkg::word_t result0;
  mem_stage_pkg::word_t result1;
  logic request;
  logic done;
  logic load0;
  logic load1;

  access_decode i_access_decode (.pair(r), .request(request), .req(dec_req));

  bus_cycle i_bus_cycle (
    .clock(clock), .reset(reset), .request(request), .req_in(dec_req),
    .wb_req(wb_req), .wb_rsp(wb_rsp), .done(done), .rdata(rdata)
  );

  load_align i_load_align0 (
    .rdata(rdata), .offset(r.calc0.address[1:0]), .width(r.calc0.width), .result(result0)
  );

  load_align i_load_align1 (
    .rdata(rdata), .offset(r.calc1.address[1:0]), .width(r.calc1.width), .result(result1)
  );

  always_comb begin
    load0 = r.calc0.valid & r.calc0.load; // the bus slot when it is a load.
    load1 = r.calc1.valid & r.calc1.load &
            ~(r.calc0.valid & (r.calc0.load | r.calc0.store));
    w = r;
    if (load0) w.calc0.wdata = result0;
    if (load1) w.calc1.wdata = result1;

    // the cyc term keeps the stage held while a flushed access drains.
    stall = wb_req.cyc | (request & ~done);

    forward0.wren = r.calc0.valid & r.calc0.wren & ~(load0 & ~done);
    forward0.waddr = r.calc0.waddr;
    forward0.wdata = w.calc0.wdata;
    forward1.wren = r.calc1.valid & r.calc1.wren & ~(load1 & ~done);
    forward1.waddr = r.calc1.waddr;
    forward1.wdata = w.calc1.wdata;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      r.calc0.valid <= 1'b0;
      r.calc1.valid <= 1'b0;
      q.calc0.valid <= 1'b0;
      q.calc1.valid <= 1'b0;
    end else begin
      if (clear) begin
        r.calc0.valid <= 1'b0;
        r.calc1.valid <= 1'b0;
      end else if (!stall) begin
        r <= d;
      end
      q <= w;
      if (stall | clear) begin
        q.calc0.valid <= 1'b0;  // nothing leaves while held or flushed.
        q.calc1.valid <= 1'b0;
      end
    end
  end

endmodule

// File: logic/data_ram.sv
module data_ram (
  input logic clock,
  input logic reset,
  input mem_stage_pkg::wb_req_t wb_req,
  output mem_stage_pkg::wb_rsp_t wb_rsp
);

  localparam int DEPTH = 2 ** mem_stage_pkg::RAM_ADDR_BITS;

  mem_stage_pkg::word_t mem [DEPTH];
  mem_stage_pkg::word_t rdata;
  logic [mem_stage_pkg::RAM_ADDR_BITS-1:0] index;
  logic access;
  logic ack;

  // a new access is taken only once the previous ack has gone.
  assign access = wb_req.cyc & wb_req.stb & ~ack;
  assign index = wb_req.adr[mem_stage_pkg::RAM_ADDR_BITS-1:0];

  always_ff @(posedge clock) begin
    if (!reset) begin
      ack <= 1'b0;
    end else begin
      ack <= access;
    end
  end

  always_ff @(posedge clock) begin
    if (access) begin
      rdata <= mem[index];
      if (wb_req.we) begin
        for (int lane = 0; lane < 4; lane++) begin
          if (wb_req.sel[lane]) begin
            mem[index][lane*8 +: 8] <= wb_req.dat[lane*8 +: 8];
          end
        end
      end
    end
  end

  always_comb begin
    wb_rsp.ack = ack;
    wb_rsp.dat = rdata;
  end

endmodule

// File: logic/memory_subsystem.sv
module memory_subsystem (
  input logic clock,
  input logic reset,
  input logic clear,
  input mem_stage_pkg::pair_t d,
  output logic stall,
  output mem_stage_pkg::forward_t forward0,
  output mem_stage_pkg::forward_t forward1,
  output mem_stage_pkg::pair_t q
);

  mem_stage_pkg::wb_req_t wb_req;
  mem_stage_pkg::wb_rsp_t wb_rsp;

  memory_stage i_memory_stage (
    .clock(clock), .reset(reset), .clear(clear), .d(d), .stall(stall),
    .wb_req(wb_req), .wb_rsp(wb_rsp),
    .forward0(forward0), .forward1(forward1), .q(q)
  );

  data_ram i_data_ram (
    .clock(clock), .reset(reset), .wb_req(wb_req), .wb_rsp(wb_rsp)
  );

endmodule

// File: testbench/tb_memory_subsystem.sv
module tb_memory_subsystem;

  localparam int RESET_CYCLES = 5;
  localparam int FILL_PAIRS = 64;
  localparam int RANDOM_PAIRS = 300;
  localparam int TOTAL_PAIRS = FILL_PAIRS + RANDOM_PAIRS;
  localparam logic [31:0] WINDOW_BASE = 32'h0000_0400; // 64 words at RAM word 256.

  logic clock;
  logic reset;
  logic clear;
  mem_stage_pkg::pair_t d;
  logic stall;
  mem_stage_pkg::forward_t forward0;
  mem_stage_pkg::forward_t forward1;
  mem_stage_pkg::pair_t q;

  logic [31:0] lcg_state = 32'h4a07_7716;
  mem_stage_pkg::word_t ref_mem [64]; // mirror of the RAM window.
  mem_stage_pkg::pair_t expected [$];

  memory_subsystem i_dut (
    .clock(clock), .reset(reset), .clear(clear), .d(d), .stall(stall),
    .forward0(forward0), .forward1(forward1), .q(q)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic mem_stage_pkg::word_t fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
  endfunction

  // kind 0 is an alu op, 1 a load, 2 a store and 3 an empty slot.
  function automatic mem_stage_pkg::calc_t random_slot(input int kind);
    mem_stage_pkg::calc_t c;
    logic [31:0] rnd;
    logic [1:0] sz;
    logic [1:0] lane;
    rnd = next_random();
    sz = (rnd[1:0] == 2'b11) ? 2'b10 : rnd[1:0];
    case (sz)
      2'b00: lane = rnd[5:4];
      2'b01: lane = {rnd[5], 1'b0};
      default: lane = 2'b00;
    endcase
    c.valid = (kind != 3);
    c.load = (kind == 1);
    c.store = (kind == 2);
    c.wren = (kind != 2) & (rnd[20] | rnd[21]);
    c.waddr = rnd[28:24];
    c.width = {rnd[2] & c.load & (sz != 2'b10), sz};
    c.address = WINDOW_BASE | {24'h0, rnd[13:8], lane};
    c.sdata = next_random();
    c.wdata = next_random();
    return c;
  endfunction

  function automatic mem_stage_pkg::pair_t random_pair();
    mem_stage_pkg::pair_t p;
    int k0;
    int k1;
    k0 = next_random() % 4;
    k1 = next_random() % 4;
    p.calc0 = random_slot(k0);
    p.calc1 = random_slot(k1);
    return p;
  endfunction

  function automatic mem_stage_pkg::word_t load_value(input mem_stage_pkg::word_t word,
      input logic [1:0] lane, input mem_stage_pkg::width_t width);
    mem_stage_pkg::word_t v;
    v = word >> (8 * lane);
    case (width[1:0])
      2'b00: v = width[2] ? {24'h0, v[7:0]} : {{24{v[7]}}, v[7:0]};
      2'b01: v = width[2] ? {16'h0, v[15:0]} : {{16{v[15]}}, v[15:0]};
      default: v = word;
    endcase
    return v;
  endfunction

  // applies the pair's memory op to the mirror and returns the pair as q shows it.
  function automatic mem_stage_pkg::pair_t expected_pair(input mem_stage_pkg::pair_t p);
    mem_stage_pkg::pair_t e;
    mem_stage_pkg::calc_t s;
    logic use1;
    logic [5:0] i;
    e = p;
    use1 = !(p.calc0.valid && (p.calc0.load || p.calc0.store));
    s = use1 ? p.calc1 : p.calc0;
    i = s.address[7:2];
    if (s.valid && s.store) begin
      case (s.width[1:0])
        2'b00: ref_mem[i][8 * s.address[1:0] +: 8] = s.sdata[7:0];
        2'b01: ref_mem[i][16 * s.address[1] +: 16] = s.sdata[15:0];
        default: ref_mem[i] = s.sdata;
      endcase
    end else if (s.valid && s.load) begin
      if (use1) e.calc1.wdata = load_value(ref_mem[i], s.address[1:0], s.width);
      else e.calc0.wdata = load_value(ref_mem[i], s.address[1:0], s.width);
    end
    return e;
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
      input logic [31:0] want);
    if (actual !== want) begin
      $display("error %s: got %h, expected %h", name, actual, want);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic check_slot(input string name, input string fwd_name,
      input mem_stage_pkg::calc_t actual, input mem_stage_pkg::calc_t want,
      input mem_stage_pkg::forward_t fwd);
    check_value({name, ".valid"}, actual.valid, want.valid);
    if (want.valid) begin
      check_value({name, ".wren"}, actual.wren, want.wren);
      check_value({name, ".waddr"}, actual.waddr, want.waddr);
      check_value({name, ".wdata"}, actual.wdata, want.wdata);
    end
    check_value({fwd_name, ".wren"}, fwd.wren, want.valid & want.wren);
    if (want.valid && want.wren) begin
      check_value({fwd_name, ".waddr"}, fwd.waddr, want.waddr);
      check_value({fwd_name, ".wdata"}, fwd.wdata, want.wdata);
    end
  endtask

  // holds d until the stage takes it, then optionally flushes it out again.
  task automatic send_pair(input mem_stage_pkg::pair_t p, input logic flush);
    mem_stage_pkg::pair_t e;
    d = p;
    @(negedge clock);
    while (stall) begin
      @(negedge clock);
    end
    e = expected_pair(p); // a flushed store still reaches memory.
    if (!flush && (p.calc0.valid || p.calc1.valid)) begin
      expected.push_back(e);
    end
    @(posedge clock);
    #1;
    d = '0;
    if (flush) begin
      clear = 1'b1;
      @(posedge clock);
      #1;
      clear = 1'b0;
    end
  endtask

  initial begin : run_tests
    mem_stage_pkg::pair_t p;
    mem_stage_pkg::calc_t s;
    reset = 1'b0;
    clear = 1'b0;
    d = '0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b1;

    // word stores fill the window, alternating between the two slots.
    for (int i = 0; i < FILL_PAIRS; i++) begin
      s = random_slot(2);
      s.width = 3'b010;
      s.address = WINDOW_BASE + 32'(4 * i);
      s.sdata = fill_word(s.address);
      p.calc0 = i[0] ? random_slot(0) : s;
      p.calc1 = i[0] ? s : random_slot(0);
      send_pair(p, 1'b0);
    end

    for (int i = 0; i < RANDOM_PAIRS; i++) begin
      p = random_pair();
      send_pair(p, (next_random() % 8) == 0);
    end

    while (expected.size() != 0) begin
      @(negedge clock);
    end
    repeat (4) @(negedge clock); // room for a stray extra result to show up.
    $display("No errors");
    $finish;
  end

  initial begin : compare_results
    mem_stage_pkg::pair_t want;
    mem_stage_pkg::forward_t fwd0_prev;
    mem_stage_pkg::forward_t fwd1_prev;
    wait (reset === 1'b1);
    forever begin
      @(negedge clock);
      if (q.calc0.valid === 1'b1 || q.calc1.valid === 1'b1) begin
        if (expected.size() == 0) begin
          report_failure("q showed a result while no accepted pair was waiting for it");
        end else begin
          want = expected.pop_front();
          check_slot("q.calc0", "forward0", q.calc0, want.calc0, fwd0_prev);
          check_slot("q.calc1", "forward1", q.calc1, want.calc1, fwd1_prev);
        end
      end
      fwd0_prev = forward0; // forwarding of the last cycle before q.
      fwd1_prev = forward1;
    end
  end

  initial begin : watchdog
    repeat (RESET_CYCLES + 20 * TOTAL_PAIRS) @(posedge clock);
    report_failure("the run took too long and not every pair came out of the stage");
  end

endmodule

// File: files.f
logic/mem_stage_pkg.sv
logic/access_decode.sv
logic/bus_cycle.sv
logic/load_align.sv
logic/memory_stage.sv
logic/data_ram.sv
logic/memory_subsystem.sv
testbench/tb_memory_subsystem.sv

// File: Bender.yml
package:
  name: memory_subsystem

sources:
  - logic/mem_stage_pkg.sv
  - logic/access_decode.sv
  - logic/bus_cycle.sv
  - logic/load_align.sv
  - logic/memory_stage.sv
  - logic/data_ram.sv
  - logic/memory_subsystem.sv
  - target: test
    files:
      - testbench/tb_memory_subsystem.sv
